// ==== design/debugPkg.sv ====
package debugPkg;

    // ================================================
    // Basic widths
    // ================================================

    // One byte on the serial link
    typedef logic [7:0] byteT;

    // Largest payload a frame can carry into the handler
    parameter int maxPayloadLen = 5;

    // ================================================
    // Message types
    // ================================================

    // Type zero fills idle time on the link
    // ReadMem stays reserved and is echoed like any unknown type
    typedef enum logic [7:0] {
        msgNop     = 8'd0,
        msgSetLed  = 8'd1,
        msgReadMem = 8'd2
    } msgTypeT;

    // Whole received frame, type in the top byte
    typedef struct packed {
        msgTypeT                      msgType;
        byteT                         payloadLen;
        byteT [maxPayloadLen-1:0]     payload;
    } msgT;

    // ================================================
    // Message sender FSM
    // ================================================
    typedef enum logic [2:0] {
        idle,
        sendLen,
        sendPayload,
        waitPayload,
        finish
    } txStateT;

endpackage

// ==== design/msgOutIf.sv ====
`timescale 1ns/1ns

// Outgoing message from the command handler to the sender
interface msgOutIf;
    import debugPkg::*;

    // Non-zero type starts a message
    msgTypeT msgType;
    byteT    payloadLen;

    // Next payload byte, valid the cycle after a strobe
    byteT    payload;

    // Sender asks for the next byte
    logic    payloadStrobe;

    modport handler (
        output msgType,
        output payloadLen,
        output payload,
        input  payloadStrobe
    );

    modport sender (
        input  msgType,
        input  payloadLen,
        input  payload,
        output payloadStrobe
    );

endinterface

// ==== design/syncQueue.sv ====
`timescale 1ns/1ns

module syncQueue #(
    parameter int Width = 8,
    parameter int Depth = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             push,
    input  logic [Width-1:0] pushData,
    input  logic             pop,
    output logic [Width-1:0] popData,
    output logic             notEmpty,
    output logic             notFull
);
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    logic [Width-1:0] mem [Depth];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  count;
    logic             doPush;
    logic             doPop;

    // Wrap for depths that are not a power of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        nextPtr = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign notEmpty = (count != '0);
    assign notFull  = (count != CntW'(Depth));

    // Push into full and pop from empty fall through here
    assign doPush = push && notFull;
    assign doPop  = pop && notEmpty;

    // Head entry shown without a read cycle
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop keep the count
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/serialRx.sv ====
`timescale 1ns/1ns

module serialRx #(
    parameter int MaxPayloadLen = debugPkg::maxPayloadLen
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           chipSel,
    input  logic           dataIn,
    output logic           push,
    output debugPkg::msgT  msg,
    input  logic           notFull
);
    import debugPkg::*;

    typedef enum logic [1:0] {
        waitType,
        waitLen,
        payload
    } rxStateT;

    rxStateT    state;
    logic [8:0] shiftReg;
    logic       byteReady;
    byteT       rxByte;
    byteT       payloadCnt;
    logic       lastByte;

    // ================================================
    // Bit shifter
    // ================================================

    // Sentinel reaches bit 8 once eight data bits are in
    assign byteReady = shiftReg[8];
    assign rxByte    = shiftReg[7:0];

    // Final payload byte of the frame just completed
    assign lastByte = byteReady && (payloadCnt + 8'd1 == msg.payloadLen);

    // ================================================
    // Deframer control
    // ================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftReg   <= 9'd1;
            state      <= waitType;
            payloadCnt <= '0;
            push       <= 1'b0;
        end else if (!chipSel) begin
            // Idle link restarts framing
            shiftReg   <= 9'd1;
            state      <= waitType;
            payloadCnt <= '0;
            push       <= 1'b0;
        end else begin
            push <= 1'b0;
            if (byteReady) begin
                // Fresh sentinel plus the first bit of the next byte
                shiftReg <= {8'd1, dataIn};
            end else begin
                shiftReg <= {shiftReg[7:0], dataIn};
            end

            case (state)
                waitType: begin
                    // Zero bytes between frames are filler
                    if (byteReady && rxByte != '0) begin
                        state <= waitLen;
                    end
                end
                waitLen: begin
                    if (byteReady) begin
                        payloadCnt <= '0;
                        state      <= payload;
                    end
                end
                payload: begin
                    if (payloadCnt == msg.payloadLen) begin
                        // Empty payload
                        push  <= notFull;
                        state <= waitType;
                    end else if (byteReady) begin
                        payloadCnt <= payloadCnt + 8'd1;
                        if (lastByte) begin
                            push  <= notFull;
                            state <= waitType;
                        end
                    end
                end
                default: state <= waitType;
            endcase
        end
    end

    // ================================================
    // Message assembly
    // ================================================
    always_ff @(posedge clk) begin
        if (chipSel && byteReady) begin
            case (state)
                waitType: begin
                    if (rxByte != '0) begin
                        msg.msgType <= msgTypeT'(rxByte);
                        // Unused payload bytes read back as zero
                        msg.payload <= '0;
                    end
                end
                waitLen: msg.payloadLen <= rxByte;
                payload: begin
                    // Bytes past the limit are consumed only
                    if (payloadCnt < MaxPayloadLen) begin
                        msg.payload[payloadCnt] <= rxByte;
                    end
                end
                default: msg <= msg;
            endcase
        end
    end

endmodule

// ==== design/serialTx.sv ====
`timescale 1ns/1ns

module serialTx (
    input  logic           clk,
    input  logic           rstN,
    input  logic           chipSel,
    output logic           dataOut,
    output logic           pop,
    input  debugPkg::byteT popData,
    input  logic           notEmpty
);
    // Byte in the top eight bits, sentinel below it
    logic [8:0] shiftReg;
    logic       boundary;

    // MSB goes out first
    assign dataOut = shiftReg[8];

    // Sentinel at bit 7 means the last bit of the byte is on the pin
    assign boundary = chipSel && (shiftReg[7:0] == 8'h80);

    // Head is taken in the same cycle it is loaded
    assign pop = boundary && notEmpty;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= 9'd1;
        end else if (!chipSel) begin
            // Zero byte with sentinel, so the first byte out is always zero
            shiftReg <= 9'd1;
        end else if (boundary) begin
            if (notEmpty) begin
                shiftReg <= {popData, 1'b1};
            end else begin
                // Nothing queued, fill with a zero byte
                shiftReg <= 9'd1;
            end
        end else begin
            shiftReg <= shiftReg << 1;
        end
    end

endmodule

// ==== design/msgSender.sv ====
`timescale 1ns/1ns

module msgSender (
    input  logic           clk,
    input  logic           rstN,
    msgOutIf.sender        msgOut,
    output logic           push,
    output debugPkg::byteT pushData,
    input  logic           notFull
);
    import debugPkg::*;

    txStateT state;
    byteT    lenLeft;
    logic    free;

    // Output slot is empty or drains this cycle
    assign free = !push || notFull;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state                <= idle;
            push                 <= 1'b0;
            pushData             <= '0;
            lenLeft              <= '0;
            msgOut.payloadStrobe <= 1'b0;
        end else begin
            // Strobe lasts one cycle
            msgOut.payloadStrobe <= 1'b0;

            // Byte taken by the queue
            if (push && notFull) begin
                push <= 1'b0;
            end

            case (state)
                idle: begin
                    if (msgOut.msgType != msgNop && free) begin
                        pushData <= byteT'(msgOut.msgType);
                        push     <= 1'b1;
                        lenLeft  <= msgOut.payloadLen;
                        state    <= sendLen;
                    end
                end
                sendLen: begin
                    if (free) begin
                        pushData             <= lenLeft;
                        push                 <= 1'b1;
                        // Requests byte 0, or closes an empty message
                        msgOut.payloadStrobe <= 1'b1;
                        state <= (lenLeft == '0) ? finish : waitPayload;
                    end
                end
                waitPayload: begin
                    // Handler updates the payload byte here
                    state <= sendPayload;
                end
                sendPayload: begin
                    // Stall while the queue is full
                    if (free) begin
                        pushData             <= msgOut.payload;
                        push                 <= 1'b1;
                        msgOut.payloadStrobe <= 1'b1;
                        lenLeft              <= lenLeft - 8'd1;
                        if (lenLeft == 8'd1) begin
                            state <= finish;
                        end else begin
                            state <= waitPayload;
                        end
                    end
                end
                finish: begin
                    // Handler drops the type after the final strobe
                    if (msgOut.msgType == msgNop) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== design/cmdHandler.sv ====
`timescale 1ns/1ns

module cmdHandler (
    input  logic          clk,
    input  logic          rstN,
    output logic          pop,
    input  debugPkg::msgT msgIn,
    input  logic          notEmpty,
    msgOutIf.handler      msgOut,
    output logic [3:0]    led
);
    import debugPkg::*;

    typedef enum logic [1:0] {
        accept,
        execute,
        reply
    } cmdStateT;

    cmdStateT state;
    msgT      req;
    byteT     remaining;

    // One message per pop, only when one is waiting
    assign pop = (state == accept) && notEmpty;

    // Request copy
    always_ff @(posedge clk) begin
        if (pop) begin
            req <= msgIn;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state             <= accept;
            led               <= '0;
            remaining         <= '0;
            msgOut.msgType    <= msgNop;
            msgOut.payloadLen <= '0;
            msgOut.payload    <= '0;
        end else begin
            case (state)
                accept: begin
                    if (pop) begin
                        state <= execute;
                    end
                end
                execute: begin
                    state <= reply;
                    case (req.msgType)
                        // Nothing to answer
                        msgNop: state <= accept;
                        msgSetLed: begin
                            led[0]            <= req.payload[0][0];
                            msgOut.msgType    <= msgSetLed;
                            msgOut.payloadLen <= 8'd1;
                            remaining         <= 8'd1;
                        end
                        default: begin
                            // Echo with empty payload
                            msgOut.msgType    <= req.msgType;
                            msgOut.payloadLen <= '0;
                            remaining         <= '0;
                        end
                    endcase
                end
                reply: begin
                    if (msgOut.payloadStrobe) begin
                        if (remaining == '0) begin
                            // Strobe after the final byte ends the reply
                            msgOut.msgType <= msgNop;
                            state          <= accept;
                        end else begin
                            // LED state, already updated in execute
                            msgOut.payload <= {4'b0000, led};
                            remaining      <= remaining - 8'd1;
                        end
                    end
                end
                default: state <= accept;
            endcase
        end
    end

endmodule

// ==== design/debugTop.sv ====
`timescale 1ns/1ns

module debugTop #(
    parameter int MaxPayloadLen = debugPkg::maxPayloadLen
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       chipSel,
    input  logic       dataIn,
    output logic       dataOut,
    output logic [3:0] led
);
    import debugPkg::*;

    localparam int InDepth  = 4;
    localparam int OutDepth = 8;

    // ================================================
    // Inbound path
    // ================================================
    logic inPush;
    logic inPop;
    logic inNotEmpty;
    logic inNotFull;
    msgT  inMsg;
    msgT  inHead;

    serialRx #(
        .MaxPayloadLen(MaxPayloadLen)
    ) rx (
        .clk     (clk),
        .rstN    (rstN),
        .chipSel (chipSel),
        .dataIn  (dataIn),
        .push    (inPush),
        .msg     (inMsg),
        .notFull (inNotFull)
    );

    // Whole messages
    syncQueue #(
        .Width ($bits(msgT)),
        .Depth (InDepth)
    ) inQueue (
        .clk      (clk),
        .rstN     (rstN),
        .push     (inPush),
        .pushData (inMsg),
        .pop      (inPop),
        .popData  (inHead),
        .notEmpty (inNotEmpty),
        .notFull  (inNotFull)
    );

    msgOutIf msgOutBus ();

    cmdHandler handler (
        .clk      (clk),
        .rstN     (rstN),
        .pop      (inPop),
        .msgIn    (inHead),
        .notEmpty (inNotEmpty),
        .msgOut   (msgOutBus.handler),
        .led      (led)
    );

    // ================================================
    // Outbound path
    // ================================================
    logic outPush;
    logic outPop;
    logic outNotEmpty;
    logic outNotFull;
    byteT outPushData;
    byteT outHead;

    msgSender sender (
        .clk      (clk),
        .rstN     (rstN),
        .msgOut   (msgOutBus.sender),
        .push     (outPush),
        .pushData (outPushData),
        .notFull  (outNotFull)
    );

    // Single bytes
    syncQueue #(
        .Width ($bits(byteT)),
        .Depth (OutDepth)
    ) outQueue (
        .clk      (clk),
        .rstN     (rstN),
        .push     (outPush),
        .pushData (outPushData),
        .pop      (outPop),
        .popData  (outHead),
        .notEmpty (outNotEmpty),
        .notFull  (outNotFull)
    );

    serialTx tx (
        .clk      (clk),
        .rstN     (rstN),
        .chipSel  (chipSel),
        .dataOut  (dataOut),
        .pop      (outPop),
        .popData  (outHead),
        .notEmpty (outNotEmpty)
    );

endmodule

// ==== test/debugTop_assertions.sv ====
`timescale 1ns/1ns

// Queue and sender control rules
// Bound to every queue and to the message sender
module debugTopAssertions #(
    parameter int PtrW = 1
) (
    input logic            clk,
    input logic            rstN,
    input logic            push,
    input logic            notFull,
    input logic            pop,
    input logic            notEmpty,
    input logic [PtrW-1:0] wrPtr,
    input logic [PtrW-1:0] rdPtr,
    input logic            strobe
);

    // ================================================
    // Queue rules
    // ================================================

    // Write pointer holds when a push meets a full queue
    fullPushIgnored: assert property (@(posedge clk) disable iff (!rstN)
        (push && !notFull) |=> $stable(wrPtr))
        else $error("push accepted while the queue was full");

    // Read pointer holds when a pop meets an empty queue
    emptyPopIgnored: assert property (@(posedge clk) disable iff (!rstN)
        (pop && !notEmpty) |=> $stable(rdPtr))
        else $error("pop honoured while the queue was empty");

    // ================================================
    // Sender rules
    // ================================================

    // One cycle per payload request
    strobeSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        strobe |=> !strobe)
        else $error("payloadStrobe held for more than one cycle");

endmodule

// Queue checks, strobe tied off
bind syncQueue debugTopAssertions #(
    .PtrW (PtrW)
) queueChecks (
    .clk      (clk),
    .rstN     (rstN),
    .push     (push),
    .notFull  (notFull),
    .pop      (pop),
    .notEmpty (notEmpty),
    .wrPtr    (wrPtr),
    .rdPtr    (rdPtr),
    .strobe   (1'b0)
);

// Strobe check only, queue inputs held idle
bind msgSender debugTopAssertions #(
    .PtrW (1)
) senderChecks (
    .clk      (clk),
    .rstN     (rstN),
    .push     (1'b0),
    .notFull  (1'b1),
    .pop      (1'b0),
    .notEmpty (1'b1),
    .wrPtr    (1'b0),
    .rdPtr    (1'b0),
    .strobe   (msgOut.payloadStrobe)
);

// ==== test/debugTopTb.sv ====
`timescale 1ns/1ns

module debugTopTb;
    import debugPkg::*;

    localparam int resetCycles  = 10;
    localparam int idleBytes    = 4;
    localparam int replyTimeout = 200;
    localparam int numSteps     = 11;

    // One request and the reply it should produce
    typedef struct packed {
        int         gap;
        byteT       reqType;
        byteT       reqLen;
        byteT       payload0;
        logic       randFill;
        logic       collect;
        msgTypeT    expType;
        byteT       expLen;
        byteT       expPayload;
        logic [3:0] expLed;
    } stepT;

    logic       clk;
    logic       rstN;
    logic       chipSel;
    logic       dataIn;
    logic       dataOut;
    logic [3:0] led;

    integer     seed;
    stepT       steps [numSteps];
    byteT       rxBytes [$];
    int         pending [$];

    debugTop #(
        .MaxPayloadLen (maxPayloadLen)
    ) UUT (
        .clk     (clk),
        .rstN    (rstN),
        .chipSel (chipSel),
        .dataIn  (dataIn),
        .dataOut (dataOut),
        .led     (led)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ================================================
    // Stop and compare tasks
    // ================================================
    task automatic abortRun();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkType(input msgTypeT got, input msgTypeT exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
            abortRun();
        end
    endtask

    task automatic checkByte(input byteT got, input byteT exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s expected %02h got %02h", $time, what, exp, got);
            abortRun();
        end
    endtask

    task automatic checkLed(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
            abortRun();
        end
    endtask

    // ================================================
    // Serial link
    // ================================================

    // Entered just after a rising edge, leaves just after one
    // Output sampled on the falling edge where it is stable
    task automatic exchangeByte(input byteT txByte);
        byteT got;
        int   i;
        got = '0;
        for (i = 7; i >= 0; i--) begin
            dataIn <= txByte[i];
            @(negedge clk);
            got = {got[6:0], dataOut};
            @(posedge clk);
        end
        rxBytes.push_back(got);
    endtask

    // Filler, type, length, payload
    task automatic sendFrame(input stepT step);
        byteT b;
        int   i;
        for (i = 0; i < step.gap; i++) begin
            exchangeByte(8'h00);
        end
        exchangeByte(step.reqType);
        exchangeByte(step.reqLen);
        for (i = 0; i < int'(step.reqLen); i++) begin
            if (step.randFill) begin
                b = byteT'($random(seed));
            end else if (i == 0) begin
                b = step.payload0;
            end else begin
                b = 8'h00;
            end
            exchangeByte(b);
        end
    endtask

    // Oldest output byte, clocking one more in if none is held
    task automatic nextReplyByte(output byteT b);
        if (rxBytes.size() == 0) begin
            exchangeByte(8'h00);
        end
        b = rxBytes.pop_front();
    endtask

    // Leading zeros skipped, then the frame compared byte by byte
    task automatic collectReply(input stepT step);
        byteT b;
        int   waited;
        waited = 0;
        nextReplyByte(b);
        while (b == 8'h00) begin
            waited++;
            if (waited >= replyTimeout) begin
                $display("timeout: no reply frame within %0d bytes at %0t", replyTimeout, $time);
                abortRun();
            end else begin
                nextReplyByte(b);
            end
        end
        checkType(msgTypeT'(b), step.expType, "reply type");
        nextReplyByte(b);
        checkByte(b, step.expLen, "reply length");
        if (step.expLen != 8'd0) begin
            nextReplyByte(b);
            checkByte(b, step.expPayload, "reply payload");
        end
    endtask

    // ================================================
    // Stimulus table
    // ================================================
    function automatic stepT makeStep(
        input int         gap,
        input byteT       reqType,
        input byteT       reqLen,
        input byteT       payload0,
        input logic       randFill,
        input logic       collect,
        input msgTypeT    expType,
        input byteT       expLen,
        input byteT       expPayload,
        input logic [3:0] expLed
    );
        stepT s;
        s.gap        = gap;
        s.reqType    = reqType;
        s.reqLen     = reqLen;
        s.payload0   = payload0;
        s.randFill   = randFill;
        s.collect    = collect;
        s.expType    = expType;
        s.expLen     = expLen;
        s.expPayload = expPayload;
        s.expLed     = expLed;
        return s;
    endfunction

    task automatic loadSteps();
        // LED on, then off
        steps[0]  = makeStep(0, 8'd1, 8'd1, 8'h01, 1'b0, 1'b1, msgSetLed, 8'd1, 8'h01, 4'h1);
        steps[1]  = makeStep(0, 8'd1, 8'd1, 8'h00, 1'b0, 1'b1, msgSetLed, 8'd1, 8'h00, 4'h0);
        // Unknown types echoed with an empty payload
        steps[2]  = makeStep(0, 8'd2, 8'd3, 8'h00, 1'b1, 1'b1, msgReadMem, 8'd0, 8'h00, 4'h0);
        steps[3]  = makeStep(0, 8'd7, 8'd3, 8'h00, 1'b1, 1'b1, msgTypeT'(8'd7), 8'd0, 8'h00, 4'h0);
        // Filler bytes ahead of the frame
        steps[4]  = makeStep(3, 8'd1, 8'd1, 8'h01, 1'b0, 1'b1, msgSetLed, 8'd1, 8'h01, 4'h1);
        // Payload longer than the limit
        steps[5]  = makeStep(2, 8'd2, 8'd8, 8'h00, 1'b1, 1'b1, msgReadMem, 8'd0, 8'h00, 4'h1);
        steps[6]  = makeStep(0, 8'd1, 8'd1, 8'h00, 1'b0, 1'b1, msgSetLed, 8'd1, 8'h00, 4'h0);
        // Back to back, replies read after the last one
        steps[7]  = makeStep(0, 8'd1, 8'd1, 8'h01, 1'b0, 1'b0, msgSetLed, 8'd1, 8'h01, 4'h1);
        steps[8]  = makeStep(0, 8'd7, 8'd3, 8'h00, 1'b1, 1'b0, msgTypeT'(8'd7), 8'd0, 8'h00, 4'h1);
        steps[9]  = makeStep(0, 8'd1, 8'd1, 8'h00, 1'b0, 1'b0, msgSetLed, 8'd1, 8'h00, 4'h0);
        steps[10] = makeStep(0, 8'd2, 8'd0, 8'h00, 1'b0, 1'b1, msgReadMem, 8'd0, 8'h00, 4'h0);
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        int   idx;
        int   k;
        byteT b;

        clk     = 1'b0;
        rstN    = 1'b0;
        chipSel = 1'b1;
        dataIn  = 1'b0;
        seed    = 32'hbcf3922b;
        loadSteps();

        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        // Idle link before any request
        for (k = 0; k < idleBytes; k++) begin
            exchangeByte(8'h00);
            b = rxBytes.pop_front();
            checkByte(b, 8'h00, "idle output byte");
            checkLed(led, 4'h0, "led after reset");
        end

        for (idx = 0; idx < numSteps; idx++) begin
            sendFrame(steps[idx]);
            pending.push_back(idx);
            if (steps[idx].collect) begin
                // Replies come back in request order
                while (pending.size() > 0) begin
                    collectReply(steps[pending.pop_front()]);
                end
                checkLed(led, steps[idx].expLed, "led state");
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== debugTop.f ====
design/debugPkg.sv
design/msgOutIf.sv
design/syncQueue.sv
design/serialRx.sv
design/serialTx.sv
design/msgSender.sv
design/cmdHandler.sv
design/debugTop.sv
test/debugTop_assertions.sv
test/debugTopTb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module debugTopTb -f debugTop.f --Mdir obj_dir -o debugTopSim

run: compile
	./obj_dir/debugTopSim

clean:
	rm -rf obj_dir
